/* verification/fir_testdata.txt */
# C addr coef writes one coefficient, all fields hex
# S in out sat gives a sample with its expected output and saturation flag, all hex
# impulse of 127/128 through the reset set
S 7F 81 0
S 00 3F 0
S 00 E0 0
S 00 0F 0
S 00 00 0
# impulse of -1 clips on tap 0
S 80 7F 1
S 00 C0 0
S 00 20 0
S 00 F0 0
S 40 C0 0
S 20 00 0
S F0 10 0
S 7F 80 1
S 81 7F 1
S 05 99 0
S FB 37 0
S 33 B9 0
# new tap 0 coefficient, older taps carry over
C 0 20
S 10 1F 0
# all positive set, full scale inputs of one sign
C 2 20
C 3 20
S 7F 33 0
S 7F 70 0
S 7F 7F 1
S 7F 7F 1
S 80 5F 0
S 80 DF 0
S 80 9F 0
S 80 80 1
S 00 80 0
S 00 C0 0
S 00 E0 0
S 00 00 0
# small values show truncation toward minus infinity
C 0 80
S 01 FF 0
S 01 FF 0
S 02 FE 0
S 7E 83 0

/* sources.f */
+incdir+logic
logic/fir_pkg.sv
logic/fir_ctl_if.sv
logic/fir_coeff_bank.sv
logic/fir_tap_line.sv
logic/fir_mac.sv
logic/fir_ctrl.sv
logic/fir_top.sv
verification/fir_tb.sv

/* Makefile */
# Verilator build and run of the FIR testbench

obj_dir/Vfir_tb: sources.f $(wildcard logic/*.sv logic/*.svh verification/*.sv)
	verilator --binary --assert -f sources.f --top-module fir_tb

run: obj_dir/Vfir_tb
	./obj_dir/Vfir_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

/* verification/fir_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_tb
  import fir_pkg::*;
();

  logic       clk;
  logic       i_srst;
  sample_t    i_in_data;
  logic       i_in_valid;
  logic       o_in_ready;
  sample_t    o_out_data;
  logic       o_out_sat;
  logic       o_out_valid;
  logic       i_out_ready;
  coef_addr_t i_coef_addr;
  coef_t      i_coef_data;
  logic       i_coef_valid;
  logic       o_coef_ready;

  // records as read, kind C or S plus up to three fields
  byte rec_kind [$];
  int  rec_a [$];
  int  rec_b [$];
  int  rec_c [$];

  // expected results in acceptance order
  sample_t exp_data_q [$];
  logic    exp_sat_q [$];

  // result that belongs to the sample on the input now
  sample_t cur_exp_data;
  logic    cur_exp_sat;

  int seed = 29459;
  int cycles = 0;
  int limit = 100;

  fir_top u_dut (
    .clk          (clk),
    .i_srst       (i_srst),
    .i_in_data    (i_in_data),
    .i_in_valid   (i_in_valid),
    .o_in_ready   (o_in_ready),
    .o_out_data   (o_out_data),
    .o_out_sat    (o_out_sat),
    .o_out_valid  (o_out_valid),
    .i_out_ready  (i_out_ready),
    .i_coef_addr  (i_coef_addr),
    .i_coef_data  (i_coef_data),
    .i_coef_valid (i_coef_valid),
    .o_coef_ready (o_coef_ready)
  );

  // 100 ns period
  always #50 clk = ~clk;

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "output data mismatch");
    end
  endtask

  task automatic check_sat(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "saturation flag mismatch");
    end
  endtask

  // falling edge, new back-pressure decision, roughly one cycle in four stalls
  task automatic next_cycle();
    @(negedge clk);
    i_out_ready = (($random(seed) & 3) != 0);
  endtask

  task automatic load_records();
    int  fd;
    int  ch;
    int  n;
    int  want;
    int  a;
    int  b;
    int  c;
    byte kind;
    fd = $fopen("verification/fir_testdata.txt", "r");
    if (fd == 0) begin
      $display("test data file verification/fir_testdata.txt could not be opened");
      $display("sim failed");
      $fatal(1, "no stimulus");
    end
    ch = $fgetc(fd);
    while (ch != -1) begin
      kind = byte'(ch);
      if (kind == "#") begin
        // skip the rest of a comment line
        while (kind != "\n" && ch != -1) begin
          ch = $fgetc(fd);
          kind = byte'(ch);
        end
      end else if (kind == "C" || kind == "S") begin
        c = 0;
        if (kind == "C") begin
          want = 2;
          n = $fscanf(fd, " %h %h", a, b);
        end else begin
          want = 3;
          n = $fscanf(fd, " %h %h %h", a, b, c);
        end
        if (n != want) begin
          $display("test data record %0d has too few fields", rec_kind.size() + 1);
          $display("sim failed");
          $fatal(1, "bad test data");
        end
        rec_kind.push_back(kind);
        rec_a.push_back(a);
        rec_b.push_back(b);
        rec_c.push_back(c);
      end else if (kind != " " && kind != "\n" && kind != "\r" && kind != "\t") begin
        $display("test data file holds a record that is neither C nor S");
        $display("sim failed");
        $fatal(1, "bad test data");
      end
      ch = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // scoreboard, outputs popped before new acceptances are queued
  always @(posedge clk) begin
    if (!i_srst) begin
      if (o_coef_ready && o_out_valid) begin
        $display("coefficient write was offered while an output was pending");
        $display("sim failed");
        $fatal(1, "write during output");
      end
      // every valid output needs an accepted sample still waiting in the queue
      if (o_out_valid && exp_data_q.size() == 0) begin
        $display("an output appeared with no accepted sample behind it");
        $display("sim failed");
        $fatal(1, "spurious output");
      end else if (o_out_valid && i_out_ready) begin
        check_sample("o_out_data", o_out_data, exp_data_q.pop_front());
        check_sat("o_out_sat", o_out_sat, exp_sat_q.pop_front());
      end
      if (i_in_valid && o_in_ready) begin
        exp_data_q.push_back(cur_exp_data);
        exp_sat_q.push_back(cur_exp_sat);
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("run did not finish within %0d cycles", limit);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int gap;
    int idle;
    bit taken;
    clk          = 1'b0;
    i_srst       = 1'b1;
    i_in_data    = '0;
    i_in_valid   = 1'b0;
    i_out_ready  = 1'b0;
    i_coef_addr  = '0;
    i_coef_data  = '0;
    i_coef_valid = 1'b0;
    cur_exp_data = '0;
    cur_exp_sat  = 1'b0;
    load_records();
    limit = 20 * rec_kind.size() + 100;
    repeat (16) @(posedge clk);
    next_cycle();
    i_srst = 1'b0;
    // idle state straight out of reset
    if (o_in_ready !== 1'b1 || o_out_valid !== 1'b0 || o_coef_ready !== 1'b0) begin
      $display("handshake outputs are not in their idle state after reset");
      $display("sim failed");
      $fatal(1, "reset state");
    end
    for (int i = 0; i < rec_kind.size(); i++) begin
      if (rec_kind[i] == "C") begin
        // held until the DUT has drained and takes it
        i_coef_addr  = coef_addr_t'(rec_a[i]);
        i_coef_data  = coef_t'(rec_b[i]);
        i_coef_valid = 1'b1;
        do begin
          @(posedge clk);
          taken = o_coef_ready;
          next_cycle();
        end while (!taken);
        i_coef_valid = 1'b0;
      end else begin
        // some samples come late, the rest back to back
        gap = $random(seed) & 3;
        if (gap == 3) begin
          repeat (2) begin
            @(posedge clk);
            next_cycle();
          end
        end
        i_in_data    = sample_t'(rec_a[i]);
        cur_exp_data = sample_t'(rec_b[i]);
        cur_exp_sat  = (rec_c[i] != 0);
        i_in_valid   = 1'b1;
        do begin
          @(posedge clk);
          taken = o_in_ready;
          next_cycle();
        end while (!taken);
        i_in_valid = 1'b0;
      end
    end
    // last results leave the pipe, then a few quiet cycles
    idle = 0;
    while (exp_data_q.size() != 0 && idle < 40) begin
      @(posedge clk);
      next_cycle();
      idle++;
    end
    repeat (4) begin
      @(posedge clk);
      next_cycle();
    end
    if (exp_data_q.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("%0d expected results never came out", exp_data_q.size());
      $display("sim failed");
      $fatal(1, "missing results");
    end
  end

endmodule

`default_nettype wire

/* logic/fir_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fir_consts.svh"

module fir_top
  import fir_pkg::*;
(
  input  wire          clk,
  input  wire          i_srst,

  // sample input
  input  sample_t      i_in_data,
  input  wire          i_in_valid,
  output logic         o_in_ready,

  // filtered output with saturation flag
  output sample_t      o_out_data,
  output logic         o_out_sat,
  output logic         o_out_valid,
  input  wire          i_out_ready,

  // coefficient write
  input  coef_addr_t   i_coef_addr,
  input  coef_t        i_coef_data,
  input  wire          i_coef_valid,
  output logic         o_coef_ready
);

  // taps and coefficients into the MAC
  sample_t taps  [0:`FIR_NTAPS-1];
  coef_t   coefs [0:`FIR_NTAPS-1];

  // enables and write strobe from control
  fir_ctl_if u_ctl_if ();

  fir_ctrl u_ctrl (
    .clk          (clk),
    .i_srst       (i_srst),
    .i_in_valid   (i_in_valid),
    .i_out_ready  (i_out_ready),
    .i_coef_valid (i_coef_valid),
    .i_coef_addr  (i_coef_addr),
    .i_coef_data  (i_coef_data),
    .o_in_ready   (o_in_ready),
    .o_out_valid  (o_out_valid),
    .o_coef_ready (o_coef_ready),
    .ctl          (u_ctl_if.ctrl)
  );

  fir_coeff_bank u_coeff_bank (
    .clk    (clk),
    .i_srst (i_srst),
    .ctl    (u_ctl_if.coef),
    .o_coef (coefs)
  );

  fir_tap_line u_tap_line (
    .clk    (clk),
    .i_srst (i_srst),
    .i_data (i_in_data),
    .ctl    (u_ctl_if.tap),
    .o_taps (taps)
  );

  fir_mac u_mac (
    .clk    (clk),
    .i_srst (i_srst),
    .i_taps (taps),
    .i_coef (coefs),
    .ctl    (u_ctl_if.mac),
    .o_data (o_out_data),
    .o_sat  (o_out_sat)
  );

endmodule

`default_nettype wire

/* logic/fir_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fir_ctrl
  import fir_pkg::*;
(
  input  wire          clk,
  input  wire          i_srst,
  input  wire          i_in_valid,
  input  wire          i_out_ready,
  input  wire          i_coef_valid,
  input  coef_addr_t   i_coef_addr,
  input  coef_t        i_coef_data,
  output logic         o_in_ready,
  output logic         o_out_valid,
  output logic         o_coef_ready,
  fir_ctl_if.ctrl      ctl
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // taps hold a sample not yet multiplied
  logic tap_vld_q;
  // product register holds a result
  logic prod_vld_q;
  // output register holds a result not yet taken
  logic out_vld_q;

  logic stall;
  logic adv;
  logic accept;
  logic empty;

  // the only stall condition in the design
  // full output with no taker freezes every stage
  assign stall = out_vld_q && !i_out_ready;
  assign adv   = !stall;
  assign empty = !tap_vld_q && !prod_vld_q && !out_vld_q;

  // samples only in RUN and only with no write waiting
  assign o_in_ready = (state_q == CTRL_RUN) && !i_coef_valid && adv;
  assign accept     = o_in_ready && i_in_valid;

  // stage enables, each stage loads only when it gets data
  assign ctl.shift_en = accept;
  assign ctl.mul_en   = adv && tap_vld_q;
  assign ctl.out_en   = adv && prod_vld_q;

  // write strobe only once the pipe is empty
  assign o_coef_ready  = (state_q == CTRL_LOAD);
  assign ctl.coef_we   = o_coef_ready && i_coef_valid;
  assign ctl.coef_addr = i_coef_addr;
  assign ctl.coef_data = i_coef_data;

  assign o_out_valid = out_vld_q;

  // occupancy moves one stage per advance
  always_ff @(posedge clk) begin
    if (i_srst) begin
      tap_vld_q  <= 1'b0;
      prod_vld_q <= 1'b0;
      out_vld_q  <= 1'b0;
    end else if (adv) begin
      tap_vld_q  <= accept;
      prod_vld_q <= tap_vld_q;
      out_vld_q  <= prod_vld_q;
    end
  end

  // write sequencing
  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_RUN: begin
        if (i_coef_valid) begin
          state_d = CTRL_DRAIN;
        end
      end
      CTRL_DRAIN: begin
        // let in-flight samples finish with the old set
        if (empty) begin
          state_d = CTRL_LOAD;
        end
      end
      CTRL_LOAD: begin
        state_d = CTRL_RUN;
      end
      default: begin
        state_d = CTRL_RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_srst) begin
      state_q <= CTRL_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // a write must never meet a sample in flight
  a_load_empty: assert property (
    @(posedge clk) disable iff (i_srst)
    $rose(o_coef_ready) |-> empty
  );

  // back-pressure at the ports freezes input, taps, products and output alike
  a_stall_freeze: assert property (
    @(posedge clk) disable iff (i_srst)
    (o_out_valid && !i_out_ready) |->
      !(o_in_ready || ctl.shift_en || ctl.mul_en || ctl.out_en)
  );

endmodule

`default_nettype wire

/* logic/fir_mac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fir_consts.svh"

module fir_mac
  import fir_pkg::*;
(
  input  wire          clk,
  input  wire          i_srst,
  input  sample_t      i_taps [0:`FIR_NTAPS-1],
  input  coef_t        i_coef [0:`FIR_NTAPS-1],
  fir_ctl_if.mac       ctl,
  output sample_t      o_data,
  output logic         o_sat
);

  // product fraction bits, 7 + 7
  localparam int NBF_PROD = `FIR_NBF_DATA + `FIR_NBF_COEF;
  // sum bits that land in the output, 14 down to 7
  localparam int KEEP_MSB = NBF_PROD + (`FIR_NB_DATA - `FIR_NBF_DATA) - 1;
  localparam int KEEP_LSB = NBF_PROD - `FIR_NBF_DATA;
  // guard slice incl. the kept sign bit
  localparam int NB_GUARD = `FIR_NB_ACC - KEEP_MSB;

  prod_t                 prod_q [0:`FIR_NTAPS-1];
  acc_t                  sum;
  logic [NB_GUARD-1:0]   guard;
  logic                  ovf;
  sample_t               res;
  sample_t               data_q;
  logic                  sat_q;

  // product stage
  // full precision, S(16,14)
  always_ff @(posedge clk) begin
    if (ctl.mul_en) begin
      for (int k = 0; k < `FIR_NTAPS; k++) begin
        prod_q[k] <= prod_t'(i_taps[k]) * prod_t'(i_coef[k]);
      end
    end
  end

  // adder chain on sign-extended products
  // two guard bits cover four terms, so no overflow here
  always_comb begin
    sum = '0;
    for (int k = 0; k < `FIR_NTAPS; k++) begin
      sum = sum + acc_t'(prod_q[k]);
    end
  end

  // saturate to S(8,7)
  // in range only if the guard bits all copy the kept sign
  always_comb begin
    guard = sum[`FIR_NB_ACC-1:KEEP_MSB];
    ovf   = !((&guard) || (~|guard));
    if (!ovf) begin
      // plain truncation, lower fraction bits dropped
      res = sum[KEEP_MSB:KEEP_LSB];
    end else if (sum[`FIR_NB_ACC-1]) begin
      // most negative
      res = {1'b1, {(`FIR_NB_DATA-1){1'b0}}};
    end else begin
      // most positive
      res = {1'b0, {(`FIR_NB_DATA-1){1'b1}}};
    end
  end

  // output stage, flag travels with its sample
  always_ff @(posedge clk) begin
    if (i_srst) begin
      data_q <= '0;
      sat_q  <= 1'b0;
    end else if (ctl.out_en) begin
      data_q <= res;
      sat_q  <= ovf;
    end
  end

  assign o_data = data_q;
  assign o_sat  = sat_q;

endmodule

`default_nettype wire

/* logic/fir_tap_line.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fir_consts.svh"

module fir_tap_line
  import fir_pkg::*;
(
  input  wire          clk,
  input  wire          i_srst,
  input  sample_t      i_data,
  fir_ctl_if.tap       ctl,
  output sample_t      o_taps [0:`FIR_NTAPS-1]
);

  // tap 0 is the sample accepted last, tap 3 the oldest
  sample_t taps_q [0:`FIR_NTAPS-1];

  // history starts at zero after reset
  // shift only on an accepted sample, hold otherwise
  always_ff @(posedge clk) begin
    if (i_srst) begin
      for (int k = 0; k < `FIR_NTAPS; k++) begin
        taps_q[k] <= '0;
      end
    end else if (ctl.shift_en) begin
      taps_q[0] <= i_data;
      for (int k = 1; k < `FIR_NTAPS; k++) begin
        taps_q[k] <= taps_q[k-1];
      end
    end
  end

  // products read all four taps in parallel
  assign o_taps = taps_q;

endmodule

`default_nettype wire

/* logic/fir_coeff_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fir_consts.svh"

module fir_coeff_bank
  import fir_pkg::*;
(
  input  wire          clk,
  input  wire          i_srst,
  fir_ctl_if.coef      ctl,
  output coef_t        o_coef [0:`FIR_NTAPS-1]
);

  // power-up set, index 0 multiplies the newest sample
  localparam coef_t RST_VAL [0:`FIR_NTAPS-1] = '{
    `FIR_COEF0_RST,
    `FIR_COEF1_RST,
    `FIR_COEF2_RST,
    `FIR_COEF3_RST
  };

  coef_t coef_q [0:`FIR_NTAPS-1];

  // one register per tap
  // only the addressed one takes the new value
  always_ff @(posedge clk) begin
    if (i_srst) begin
      for (int k = 0; k < `FIR_NTAPS; k++) begin
        coef_q[k] <= RST_VAL[k];
      end
    end else if (ctl.coef_we) begin
      coef_q[ctl.coef_addr] <= ctl.coef_data;
    end
  end

  assign o_coef = coef_q;

  // an X index would corrupt an unknown register
  a_addr_known: assert property (
    @(posedge clk) disable iff (i_srst)
    ctl.coef_we |-> !$isunknown(ctl.coef_addr)
  );

endmodule

`default_nettype wire

/* logic/fir_ctl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fir_ctl_if
  import fir_pkg::*;
();

  // tap line advances by one sample
  logic       shift_en;
  // product register loads
  logic       mul_en;
  // output register loads
  logic       out_en;

  // single coefficient write
  logic       coef_we;
  coef_addr_t coef_addr;
  coef_t      coef_data;

  // control side drives everything
  modport ctrl (
    output shift_en,
    output mul_en,
    output out_en,
    output coef_we,
    output coef_addr,
    output coef_data
  );

  modport tap (input shift_en);

  modport mac (input mul_en, input out_en);

  modport coef (input coef_we, input coef_addr, input coef_data);

endinterface

`default_nettype wire

/* logic/fir_pkg.sv */
`default_nettype none

`include "fir_consts.svh"

package fir_pkg;

  // sample in, result out
  typedef logic signed [`FIR_NB_DATA-1:0] sample_t;

  // filter coefficient
  typedef logic signed [`FIR_NB_COEF-1:0] coef_t;

  // full precision tap product
  typedef logic signed [`FIR_NB_PROD-1:0] prod_t;

  // sum of all products incl. guard bits
  typedef logic signed [`FIR_NB_ACC-1:0] acc_t;

  // coefficient index
  typedef logic [$clog2(`FIR_NTAPS)-1:0] coef_addr_t;

  // control FSM
  typedef enum logic [1:0] {
    CTRL_RUN   = 2'd0,
    CTRL_DRAIN = 2'd1,
    CTRL_LOAD  = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire

/* logic/fir_consts.svh */
`ifndef FIR_CONSTS_SVH
`define FIR_CONSTS_SVH

// number of taps, the datapath is tied to four
`define FIR_NTAPS 4

// sample and output format S(8,7)
`define FIR_NB_DATA  8
`define FIR_NBF_DATA 7

// coefficient format S(8,7)
`define FIR_NB_COEF  8
`define FIR_NBF_COEF 7

// product S(16,14), sum with two guard bits for four terms
`define FIR_NB_PROD 16
`define FIR_NB_ACC  18

// reset coefficients [-1, 1/2, -1/4, 1/8]
`define FIR_COEF0_RST 8'h80
`define FIR_COEF1_RST 8'h40
`define FIR_COEF2_RST 8'hE0
`define FIR_COEF3_RST 8'h10

`endif
